//--- verilog.f
sdram_pkg.sv
sdram_refresh_timer.sv
sdram_sequencer.sv
sdram_command_encoder.sv
sdram_read_capture.sv
sdram_controller.sv
tb_sdram_model.sv
tb_sdram_controller.sv

//--- Bender.yml
package:
  name: sdram_controller

sources:
  - files:
      - sdram_pkg.sv
      - sdram_refresh_timer.sv
      - sdram_sequencer.sv
      - sdram_command_encoder.sv
      - sdram_read_capture.sv
      - sdram_controller.sv
  - target: simulation
    files:
      - tb_sdram_model.sv
      - tb_sdram_controller.sv

//--- tb_sdram_controller.sv
// Testbench for the SDRAM controller running directed tests against a behavioral SDRAM
`timescale 1ns/1ps

module tb_sdram_controller;

    localparam int RESET_CYCLES   = 10;
    localparam int BURST_CYCLES   = 400;
    localparam int READBACK_CYCLES = 200;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + int'(sdram_pkg::INIT_WAIT) + BURST_CYCLES
                                  + int'(sdram_pkg::REFRESH_INTERVAL) + 50
                                  + READBACK_CYCLES + 1800;

    logic              sdram_clock = 1'b0;
    logic              sdram_reset;
    sdram_pkg::addr_t  address;
    sdram_pkg::col_t   access_num;
    sdram_pkg::data_t  data_in;
    sdram_pkg::data_t  data_out;
    logic              write_request;
    logic              read_request;
    logic              write_flag;
    logic              read_flag;
    logic              refresh_mode;
    logic              idle;
    sdram_pkg::row_t   sdram_address;
    logic              sdram_cke;
    logic              sdram_cs;
    logic              sdram_ras;
    logic              sdram_cas;
    logic              sdram_we;
    sdram_pkg::bank_t  sdram_ba;
    sdram_pkg::data_t  sdram_dq_in;
    sdram_pkg::data_t  sdram_dq_out;
    logic              sdram_dq_io;

    logic [31:0]       lfsr_state = 32'h319b900a;
    string             current_test = "startup";
    int                elapsed = 0;
    sdram_pkg::data_t  write_words [$];
    sdram_pkg::data_t  read_words [$];
    sdram_pkg::data_t  expected_words [$];
    sdram_pkg::data_t  burst_a [$];
    sdram_pkg::data_t  burst_b [$];

    always #20 sdram_clock = ~sdram_clock;

    sdram_controller dut (
        .sdram_clock   (sdram_clock),
        .sdram_reset   (sdram_reset),
        .address       (address),
        .access_num    (access_num),
        .data_in       (data_in),
        .data_out      (data_out),
        .write_request (write_request),
        .read_request  (read_request),
        .write_flag    (write_flag),
        .read_flag     (read_flag),
        .refresh_mode  (refresh_mode),
        .idle          (idle),
        .sdram_address (sdram_address),
        .sdram_cke     (sdram_cke),
        .sdram_cs      (sdram_cs),
        .sdram_ras     (sdram_ras),
        .sdram_cas     (sdram_cas),
        .sdram_we      (sdram_we),
        .sdram_ba      (sdram_ba),
        .sdram_dq_in   (sdram_dq_in),
        .sdram_dq_out  (sdram_dq_out),
        .sdram_dq_io   (sdram_dq_io)
    );

    tb_sdram_model model (
        .sdram_clock   (sdram_clock),
        .sdram_cke     (sdram_cke),
        .sdram_cs      (sdram_cs),
        .sdram_ras     (sdram_ras),
        .sdram_cas     (sdram_cas),
        .sdram_we      (sdram_we),
        .sdram_address (sdram_address),
        .sdram_ba      (sdram_ba),
        .sdram_dq_out  (sdram_dq_out),
        .sdram_dq_io   (sdram_dq_io),
        .sdram_dq_in   (sdram_dq_in)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge sdram_clock) begin
        elapsed++;
        if (elapsed == TIMEOUT_CYCLES)
            stop_on_error($sformatf("Timeout in %s: controller did not finish within %0d cycles",
                                    current_test, TIMEOUT_CYCLES));
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("Mismatch in %s, %s: expected %0h, actual %0h",
                                current_test, what, expected, actual));
    endtask

    task automatic compare_data(input string what, input sdram_pkg::data_t expected,
                                input sdram_pkg::data_t actual);
        if (expected !== actual)
            report_mismatch(what, 32'(expected), 32'(actual));
    endtask

    task automatic compare_count(input string what, input sdram_pkg::col_t expected,
                                 input sdram_pkg::col_t actual);
        if (expected !== actual)
            report_mismatch(what, 32'(expected), 32'(actual));
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual)
            report_mismatch(what, 32'(expected), 32'(actual));
    endtask

    task automatic compare_command(input string what, input logic [3:0] expected,
                                   input logic [3:0] actual);
        if (expected !== actual)
            report_mismatch(what, 32'(expected), 32'(actual));
    endtask

    task automatic compare_address(input string what, input sdram_pkg::row_t expected,
                                   input sdram_pkg::row_t actual);
        if (expected !== actual)
            report_mismatch(what, 32'(expected), 32'(actual));
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic sdram_pkg::data_t random_word();
        sdram_pkg::data_t word;
        logic             lsb;
        word = '0;
        for (int i = 0; i < sdram_pkg::DATA_WIDTH; i++) begin
            lsb        = lfsr_state[0];
            word       = {word[sdram_pkg::DATA_WIDTH-2:0], lsb};
            lfsr_state = lfsr_state >> 1;
            if (lsb)
                lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return word;
    endfunction

    function automatic sdram_pkg::addr_t make_address(input sdram_pkg::bank_t bank,
                                                      input sdram_pkg::row_t row,
                                                      input sdram_pkg::col_t column);
        return {bank, row, column};
    endfunction

    task automatic fill_random(input int count);
        write_words.delete();
        repeat (count)
            write_words.push_back(random_word());
    endtask

    // Inputs change 2 ns after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge sdram_clock);
        #2;
    endtask

    task automatic wait_for_idle();
        while (!idle)
            next_cycle();
    endtask

    task automatic write_burst(input sdram_pkg::addr_t addr, input int count);
        int  written;
        logic left_idle;
        written   = 0;
        left_idle = 1'b0;
        wait_for_idle();
        address       = addr;
        access_num    = sdram_pkg::col_t'(count);
        write_request = 1'b1;
        while (!(left_idle && idle)) begin
            next_cycle();
            if (!idle) begin
                left_idle     = 1'b1;
                write_request = 1'b0;
            end
            if (write_flag) begin
                if (written < write_words.size())
                    data_in = write_words[written];
                written++;
            end
        end
        compare_count("write_flag cycles", sdram_pkg::col_t'(count), sdram_pkg::col_t'(written));
    endtask

    task automatic read_burst(input sdram_pkg::addr_t addr, input int count);
        logic left_idle;
        left_idle = 1'b0;
        read_words.delete();
        wait_for_idle();
        address      = addr;
        access_num   = sdram_pkg::col_t'(count);
        read_request = 1'b1;
        while (!(left_idle && idle)) begin
            next_cycle();
            if (!idle) begin
                left_idle    = 1'b1;
                read_request = 1'b0;
            end
            if (read_flag)
                read_words.push_back(data_out);
        end
    endtask

    task automatic read_and_check(input sdram_pkg::addr_t addr, input int count);
        read_burst(addr, count);
        compare_count("read_flag cycles", sdram_pkg::col_t'(count),
                      sdram_pkg::col_t'(read_words.size()));
        for (int i = 0; i < count; i++)
            compare_data($sformatf("word %0d", i), expected_words[i], read_words[i]);
    endtask

    // Words must sit in the memory cell named by bank, row and column
    task automatic check_stored(input sdram_pkg::addr_t addr);
        sdram_pkg::addr_t key;
        for (int i = 0; i < expected_words.size(); i++) begin
            key = addr + sdram_pkg::addr_t'(i);
            if (!model.memory.exists(key))
                stop_on_error($sformatf("Nothing was written to SDRAM location %0h in %s",
                                        key, current_test));
            compare_data($sformatf("stored word %0d", i), expected_words[i], model.memory[key]);
        end
    endtask

    task automatic test_reset_state();
        current_test = "reset_state";
        repeat (RESET_CYCLES / 2)
            next_cycle();
        compare_flag("sdram_cke", 1'b0, sdram_cke);
        compare_flag("sdram_cs", 1'b1, sdram_cs);
        compare_flag("sdram_ras", 1'b1, sdram_ras);
        compare_flag("sdram_cas", 1'b1, sdram_cas);
        compare_flag("sdram_we", 1'b1, sdram_we);
        compare_flag("sdram_dq_io", 1'b1, sdram_dq_io);
        compare_flag("idle", 1'b0, idle);
        compare_flag("write_flag", 1'b0, write_flag);
        compare_flag("read_flag", 1'b0, read_flag);
        compare_flag("refresh_mode", 1'b0, refresh_mode);
        repeat (RESET_CYCLES - RESET_CYCLES / 2)
            next_cycle();
        sdram_reset = 1'b0;
    endtask

    task automatic test_init_sequence();
        current_test = "init_sequence";
        wait_for_idle();
        compare_count("commands before idle", 9'd4, sdram_pkg::col_t'(model.cmd_log.size()));
        compare_command("command 0", sdram_pkg::CMD_PRECHARGE, model.cmd_log[0]);
        compare_flag("all-bank bit", 1'b1, model.addr_log[0][sdram_pkg::AP_BIT]);
        compare_command("command 1", sdram_pkg::CMD_REFRESH, model.cmd_log[1]);
        compare_command("command 2", sdram_pkg::CMD_REFRESH, model.cmd_log[2]);
        compare_command("command 3", sdram_pkg::CMD_MRS, model.cmd_log[3]);
        // CAS latency field starts at address bit 4
        compare_address("mode word", (sdram_pkg::row_t'(sdram_pkg::CAS_LATENCY) << 4),
                        model.addr_log[3]);
    endtask

    task automatic test_single_word();
        current_test = "single_word";
        fill_random(1);
        write_burst(make_address(2'd0, 13'h0007, 9'h005), 1);
        expected_words = write_words;
        read_and_check(make_address(2'd0, 13'h0007, 9'h005), 1);
    endtask

    task automatic test_burst_eight();
        current_test = "burst_eight";
        fill_random(8);
        write_burst(make_address(2'd1, 13'h0123, 9'h1f0), 8);
        expected_words = write_words;
        read_and_check(make_address(2'd1, 13'h0123, 9'h1f0), 8);
    endtask

    task automatic test_two_banks();
        current_test = "two_banks";
        fill_random(4);
        burst_a = write_words;
        write_burst(make_address(2'd2, 13'h1abc, 9'h010), 4);
        fill_random(4);
        burst_b = write_words;
        write_burst(make_address(2'd1, 13'h0abc, 9'h010), 4);
        expected_words = burst_a;
        check_stored(make_address(2'd2, 13'h1abc, 9'h010));
        expected_words = burst_b;
        check_stored(make_address(2'd1, 13'h0abc, 9'h010));
        read_and_check(make_address(2'd1, 13'h0abc, 9'h010), 4);
        expected_words = burst_a;
        read_and_check(make_address(2'd2, 13'h1abc, 9'h010), 4);
    endtask

    task automatic test_refresh();
        int   refreshes_before;
        logic refresh_seen;
        current_test     = "refresh";
        refreshes_before = model.refresh_total;
        refresh_seen     = 1'b0;
        repeat (int'(sdram_pkg::REFRESH_INTERVAL) + 50) begin
            next_cycle();
            if (refresh_mode)
                refresh_seen = 1'b1;
        end
        compare_flag("refresh_mode seen", 1'b1, refresh_seen);
        compare_flag("new refresh command", 1'b1, model.refresh_total > refreshes_before);
        expected_words = burst_b;
        read_and_check(make_address(2'd1, 13'h0abc, 9'h010), 4);
        expected_words = burst_a;
        read_and_check(make_address(2'd2, 13'h1abc, 9'h010), 4);
    endtask

    initial begin
        sdram_reset   = 1'b1;
        address       = '0;
        access_num    = '0;
        data_in       = '0;
        write_request = 1'b0;
        read_request  = 1'b0;
        test_reset_state();
        test_init_sequence();
        test_single_word();
        test_burst_eight();
        test_two_banks();
        test_refresh();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
// Behavioral SDRAM model that stores written words, returns reads after the CAS latency and logs commands
`timescale 1ns/1ps

module tb_sdram_model (
    input  logic              sdram_clock,
    input  logic              sdram_cke,
    input  logic              sdram_cs,
    input  logic              sdram_ras,
    input  logic              sdram_cas,
    input  logic              sdram_we,
    input  sdram_pkg::row_t   sdram_address,
    input  sdram_pkg::bank_t  sdram_ba,
    input  sdram_pkg::data_t  sdram_dq_out,
    input  logic              sdram_dq_io,
    output sdram_pkg::data_t  sdram_dq_in
);

    localparam int CL = int'(sdram_pkg::CAS_LATENCY);

    logic [3:0]        command;
    sdram_pkg::data_t  memory [sdram_pkg::addr_t];
    sdram_pkg::row_t   open_row [0:(1 << sdram_pkg::BANK_WIDTH)-1];
    sdram_pkg::data_t  read_pipe [0:CL-1];
    logic [3:0]        cmd_log [$];
    sdram_pkg::row_t   addr_log [$];
    int                refresh_total = 0;

    assign command     = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
    assign sdram_dq_in = read_pipe[CL-1];

    initial begin
        for (int i = 0; i < CL; i++)
            read_pipe[i] = '0;
    end

    // Unwritten cells return a value built from every address bit
    function automatic sdram_pkg::data_t fill_word(input sdram_pkg::addr_t key);
        return key[15:0] ^ {key[23:16], key[23:16]};
    endfunction

    always @(posedge sdram_clock) begin : command_decode
        sdram_pkg::addr_t key;
        sdram_pkg::data_t word;
        int               i;
        word = '0;
        key  = {sdram_ba, open_row[sdram_ba], sdram_address[sdram_pkg::COL_WIDTH-1:0]};
        if (sdram_cke && !sdram_cs && (command != sdram_pkg::CMD_NOP)) begin
            cmd_log.push_back(command);
            addr_log.push_back(sdram_address);
            case (command)
                sdram_pkg::CMD_ACTIVE:  open_row[sdram_ba] = sdram_address;
                // Bus not driven by the controller gives garbage in the cell
                sdram_pkg::CMD_WRITE:   memory[key] = sdram_dq_io ? 'x : sdram_dq_out;
                sdram_pkg::CMD_READ:    word = memory.exists(key) ? memory[key] : fill_word(key);
                sdram_pkg::CMD_REFRESH: refresh_total++;
                default: ;
            endcase
        end
        // CAS latency pipeline
        read_pipe[0] <= word;
        for (i = 1; i < CL; i++)
            read_pipe[i] <= read_pipe[i-1];
    end

endmodule

//--- sdram_controller.sv
// SDRAM controller top joining the FSM, refresh timer, command encoder and read capture
`timescale 1ns/1ps

module sdram_controller (
    input  logic              sdram_clock,
    input  logic              sdram_reset,

    // User side
    input  sdram_pkg::addr_t  address,
    input  sdram_pkg::col_t   access_num,
    input  sdram_pkg::data_t  data_in,
    output sdram_pkg::data_t  data_out,
    input  logic              write_request,
    input  logic              read_request,
    output logic              write_flag,
    output logic              read_flag,
    output logic              refresh_mode,
    output logic              idle,

    // SDRAM pins
    output sdram_pkg::row_t   sdram_address,
    output logic              sdram_cke,
    output logic              sdram_cs,
    output logic              sdram_ras,
    output logic              sdram_cas,
    output logic              sdram_we,
    output sdram_pkg::bank_t  sdram_ba,
    input  sdram_pkg::data_t  sdram_dq_in,
    output sdram_pkg::data_t  sdram_dq_out,
    output logic              sdram_dq_io
);

    sdram_pkg::state_t state;
    logic [15:0]       cycle_count;
    sdram_pkg::col_t   burst_count;
    logic              refresh_issued;
    logic              refresh_due;
    logic              read_done;

    sdram_sequencer u_sequencer (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .write_request  (write_request),
        .read_request   (read_request),
        .access_num     (access_num),
        .refresh_due    (refresh_due),
        .read_done      (read_done),
        .state          (state),
        .cycle_count    (cycle_count),
        .burst_count    (burst_count),
        .refresh_issued (refresh_issued),
        .idle           (idle),
        .write_flag     (write_flag),
        .refresh_mode   (refresh_mode)
    );

    sdram_refresh_timer u_refresh_timer (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .refresh_issued (refresh_issued),
        .refresh_due    (refresh_due)
    );

    sdram_command_encoder u_command_encoder (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .state          (state),
        .cycle_count    (cycle_count),
        .burst_count    (burst_count),
        .write_request  (write_request),
        .read_request   (read_request),
        .address        (address),
        .access_num     (access_num),
        .data_in        (data_in),
        .sdram_address  (sdram_address),
        .sdram_cke      (sdram_cke),
        .sdram_cs       (sdram_cs),
        .sdram_ras      (sdram_ras),
        .sdram_cas      (sdram_cas),
        .sdram_we       (sdram_we),
        .sdram_ba       (sdram_ba),
        .sdram_dq_out   (sdram_dq_out),
        .sdram_dq_io    (sdram_dq_io)
    );

    sdram_read_capture u_read_capture (
        .sdram_clock    (sdram_clock),
        .sdram_reset    (sdram_reset),
        .state          (state),
        .cycle_count    (cycle_count),
        .access_num     (access_num),
        .sdram_dq_in    (sdram_dq_in),
        .data_out       (data_out),
        .read_flag      (read_flag),
        .read_done      (read_done)
    );

endmodule

//--- sdram_read_capture.sv
// Read capture that registers returned burst words after the CAS latency
`timescale 1ns/1ps

module sdram_read_capture (
    input  logic               sdram_clock,
    input  logic               sdram_reset,
    input  sdram_pkg::state_t  state,
    input  logic [15:0]        cycle_count,
    input  sdram_pkg::col_t    access_num,
    input  sdram_pkg::data_t   sdram_dq_in,
    output sdram_pkg::data_t   data_out,
    output logic               read_flag,
    output logic               read_done
);

    sdram_pkg::col_t word_count;
    logic            capture;

    // First word is on the bus once the pin register and CAS latency have passed
    assign capture = (state == sdram_pkg::read)
                  && (cycle_count > 16'(sdram_pkg::CAS_LATENCY))
                  && (word_count != access_num);

    assign read_done = (word_count == access_num);

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset) begin
            word_count <= '0;
            read_flag  <= 1'b0;
        end else begin
            read_flag <= capture;
            if (state != sdram_pkg::read)
                word_count <= '0;
            else if (capture)
                word_count <= word_count + 1'b1;
        end
    end

    always_ff @(posedge sdram_clock) begin
        if (capture)
            data_out <= sdram_dq_in;
    end

endmodule

//--- sdram_command_encoder.sv
// Command encoder that registers the SDRAM command, address, bank and data pins
`timescale 1ns/1ps

module sdram_command_encoder (
    input  logic               sdram_clock,
    input  logic               sdram_reset,
    input  sdram_pkg::state_t  state,
    input  logic [15:0]        cycle_count,
    input  sdram_pkg::col_t    burst_count,
    input  logic               write_request,
    input  logic               read_request,
    input  sdram_pkg::addr_t   address,
    input  sdram_pkg::col_t    access_num,
    input  sdram_pkg::data_t   data_in,
    output sdram_pkg::row_t    sdram_address,
    output logic               sdram_cke,
    output logic               sdram_cs,
    output logic               sdram_ras,
    output logic               sdram_cas,
    output logic               sdram_we,
    output sdram_pkg::bank_t   sdram_ba,
    output sdram_pkg::data_t   sdram_dq_out,
    output logic               sdram_dq_io
);

    logic              first_cycle;
    logic              request;
    sdram_pkg::bank_t  bank_q;
    sdram_pkg::col_t   start_col_q;
    sdram_pkg::col_t   column;
    sdram_pkg::row_t   column_address;
    sdram_pkg::row_t   all_banks_address;
    logic [3:0]        cmd_d;
    sdram_pkg::row_t   address_d;
    sdram_pkg::bank_t  ba_d;
    sdram_pkg::data_t  dq_out_d;
    logic              dq_io_d;
    logic              cke_d;

    assign first_cycle       = (cycle_count == 16'd0);
    assign request           = write_request || read_request;
    assign column            = start_col_q + burst_count;
    assign column_address    = {{(sdram_pkg::ROW_WIDTH - sdram_pkg::COL_WIDTH){1'b0}}, column};
    assign all_banks_address = sdram_pkg::row_t'(1'b1) << sdram_pkg::AP_BIT;

    // Bank and start column held for the whole burst
    always_ff @(posedge sdram_clock) begin
        if ((state == sdram_pkg::idle) && request) begin
            bank_q      <= address[sdram_pkg::BANK_LSB +: sdram_pkg::BANK_WIDTH];
            start_col_q <= address[sdram_pkg::COL_WIDTH-1:0];
        end
    end

    always_comb begin
        cmd_d     = sdram_pkg::CMD_NOP;
        address_d = '0;
        ba_d      = '0;
        dq_out_d  = '0;
        dq_io_d   = 1'b1;
        cke_d     = 1'b1;
        case (state)
            sdram_pkg::init, sdram_pkg::precharge_wait: begin
                cmd_d = sdram_pkg::CMD_NOP;
            end
            sdram_pkg::pall, sdram_pkg::refresh_pall, sdram_pkg::precharge: begin
                address_d = all_banks_address;
                if (first_cycle)
                    cmd_d = sdram_pkg::CMD_PRECHARGE;
            end
            sdram_pkg::init_cbr_1, sdram_pkg::init_cbr_2, sdram_pkg::refresh: begin
                if (first_cycle)
                    cmd_d = sdram_pkg::CMD_REFRESH;
            end
            sdram_pkg::mrs: begin
                if (first_cycle) begin
                    cmd_d     = sdram_pkg::CMD_MRS;
                    address_d = sdram_pkg::MODE_WORD;
                end
            end
            sdram_pkg::idle: begin
                // Open the row as the FSM leaves idle
                if (request) begin
                    cmd_d     = sdram_pkg::CMD_ACTIVE;
                    address_d = address[sdram_pkg::ROW_LSB +: sdram_pkg::ROW_WIDTH];
                    ba_d      = address[sdram_pkg::BANK_LSB +: sdram_pkg::BANK_WIDTH];
                end
            end
            sdram_pkg::write: begin
                cmd_d     = sdram_pkg::CMD_WRITE;
                address_d = column_address;
                ba_d      = bank_q;
                dq_out_d  = data_in;
                dq_io_d   = 1'b0;
            end
            sdram_pkg::read: begin
                if (cycle_count < 16'(access_num)) begin
                    cmd_d     = sdram_pkg::CMD_READ;
                    address_d = column_address;
                    ba_d      = bank_q;
                end
            end
            default: begin
                cmd_d = sdram_pkg::CMD_DESELECT;
                cke_d = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset) begin
            sdram_cke     <= 1'b0;
            {sdram_cs, sdram_ras, sdram_cas, sdram_we} <= sdram_pkg::CMD_DESELECT;
            sdram_address <= '0;
            sdram_ba      <= '0;
            sdram_dq_out  <= '0;
            sdram_dq_io   <= 1'b1;
        end else begin
            sdram_cke     <= cke_d;
            {sdram_cs, sdram_ras, sdram_cas, sdram_we} <= cmd_d;
            sdram_address <= address_d;
            sdram_ba      <= ba_d;
            sdram_dq_out  <= dq_out_d;
            sdram_dq_io   <= dq_io_d;
        end
    end

endmodule

//--- sdram_sequencer.sv
// Controller FSM with per-state cycle counter and burst column counter
`timescale 1ns/1ps

module sdram_sequencer (
    input  logic               sdram_clock,
    input  logic               sdram_reset,
    input  logic               write_request,
    input  logic               read_request,
    input  sdram_pkg::col_t    access_num,
    input  logic               refresh_due,
    input  logic               read_done,
    output sdram_pkg::state_t  state,
    output logic [15:0]        cycle_count,
    output sdram_pkg::col_t    burst_count,
    output logic               refresh_issued,
    output logic               idle,
    output logic               write_flag,
    output logic               refresh_mode
);

    sdram_pkg::state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            sdram_pkg::init: begin
                if (cycle_count == sdram_pkg::INIT_WAIT)
                    next_state = sdram_pkg::pall;
            end
            sdram_pkg::pall: begin
                if (cycle_count == sdram_pkg::T_RP)
                    next_state = sdram_pkg::init_cbr_1;
            end
            sdram_pkg::init_cbr_1: begin
                if (cycle_count == sdram_pkg::T_RC)
                    next_state = sdram_pkg::init_cbr_2;
            end
            sdram_pkg::init_cbr_2: begin
                if (cycle_count == sdram_pkg::T_RC)
                    next_state = sdram_pkg::mrs;
            end
            sdram_pkg::mrs: begin
                if (cycle_count == sdram_pkg::T_MRD)
                    next_state = sdram_pkg::idle;
            end
            sdram_pkg::refresh_pall: begin
                if (cycle_count == sdram_pkg::T_RP)
                    next_state = sdram_pkg::refresh;
            end
            sdram_pkg::refresh: begin
                if (cycle_count == sdram_pkg::T_RC)
                    next_state = sdram_pkg::idle;
            end
            sdram_pkg::idle: begin
                // Write wins over read, read over refresh
                if (write_request)
                    next_state = sdram_pkg::write;
                else if (read_request)
                    next_state = sdram_pkg::read;
                else if (refresh_due)
                    next_state = sdram_pkg::refresh_pall;
            end
            sdram_pkg::write: begin
                if (burst_count == access_num - 1'b1)
                    next_state = sdram_pkg::precharge_wait;
            end
            sdram_pkg::precharge_wait: begin
                if (cycle_count == sdram_pkg::T_DPL)
                    next_state = sdram_pkg::precharge;
            end
            sdram_pkg::read: begin
                // All column commands sent and every word back
                if ((cycle_count >= 16'(access_num)) && read_done)
                    next_state = sdram_pkg::precharge;
            end
            sdram_pkg::precharge: begin
                if (cycle_count == sdram_pkg::T_RP)
                    next_state = sdram_pkg::idle;
            end
            default: begin
                next_state = sdram_pkg::init;
            end
        endcase
    end

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            state <= sdram_pkg::init;
        else
            state <= next_state;
    end

    // Zero on the first cycle of every state
    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            cycle_count <= 16'd0;
        else if (next_state != state)
            cycle_count <= 16'd0;
        else
            cycle_count <= cycle_count + 16'd1;
    end

    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset)
            burst_count <= '0;
        else if ((state == sdram_pkg::write) || (state == sdram_pkg::read))
            burst_count <= burst_count + 1'b1;
        else
            burst_count <= '0;
    end

    assign refresh_issued = (state == sdram_pkg::refresh) && (cycle_count == 16'd0);
    assign idle           = (state == sdram_pkg::idle);
    assign write_flag     = (state == sdram_pkg::write);
    assign refresh_mode   = (state == sdram_pkg::refresh_pall) || (state == sdram_pkg::refresh);

endmodule

//--- sdram_refresh_timer.sv
// Refresh timer that flags when the next auto-refresh is due
`timescale 1ns/1ps

module sdram_refresh_timer (
    input  logic sdram_clock,
    input  logic sdram_reset,
    input  logic refresh_issued,
    output logic refresh_due
);

    logic [15:0] refresh_count;

    // Saturates so the due level holds until the refresh is taken
    always_ff @(posedge sdram_clock, posedge sdram_reset) begin
        if (sdram_reset) begin
            refresh_count <= 16'd0;
        end else if (refresh_issued) begin
            refresh_count <= 16'd0;
        end else if (refresh_count != sdram_pkg::REFRESH_INTERVAL) begin
            refresh_count <= refresh_count + 16'd1;
        end
    end

    assign refresh_due = (refresh_count == sdram_pkg::REFRESH_INTERVAL);

endmodule

//--- sdram_pkg.sv
// Shared widths, timing constants, command encodings and types for the SDRAM controller
package sdram_pkg;

    localparam int COL_WIDTH  = 9;
    localparam int ROW_WIDTH  = 13;
    localparam int BANK_WIDTH = 2;
    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = BANK_WIDTH + ROW_WIDTH + COL_WIDTH;

    // User address is bank over row over column
    localparam int ROW_LSB  = COL_WIDTH;
    localparam int BANK_LSB = COL_WIDTH + ROW_WIDTH;

    // Wait cycles, compared against the per-state cycle counter
    localparam logic [15:0] T_RC  = 16'd4;
    localparam logic [15:0] T_RP  = 16'd0;
    localparam logic [15:0] T_MRD = 16'd1;
    localparam logic [15:0] T_DPL = 16'd1;

    localparam logic [2:0]  CAS_LATENCY = 3'd2;

    // Shortened power-up wait for simulation
    localparam logic [15:0] INIT_WAIT        = 16'd100;
    localparam logic [15:0] REFRESH_INTERVAL = 16'd400;

    localparam logic [ROW_WIDTH-1:0] MODE_WORD = {6'b000000, CAS_LATENCY, 4'b0000};
    localparam int AP_BIT = 10;

    // Command pins {cs, ras, cas, we}
    localparam logic [3:0] CMD_DESELECT  = 4'b1111;
    localparam logic [3:0] CMD_NOP       = 4'b0111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;
    localparam logic [3:0] CMD_MRS       = 4'b0000;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [COL_WIDTH-1:0]  col_t;
    typedef logic [ROW_WIDTH-1:0]  row_t;
    typedef logic [BANK_WIDTH-1:0] bank_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef enum logic [3:0] {
        init, pall, init_cbr_1, init_cbr_2, mrs, refresh_pall,
        refresh, idle, write, precharge_wait, read, precharge
    } state_t;

endpackage
